/* rtl/fsb_axi_pkg.sv */
// ----------------------------
// fsb to axi4 write adapter
// widths, register map and shared bus types
// ----------------------------
package fsb_axi_pkg;

  // ----------------------------
  // bus widths
  // ----------------------------
  localparam int DATA_W = 512;
  localparam int STRB_W = 64;
  localparam int FSB_W  = 80;
  localparam int LANE_W = 128;
  localparam int LANES  = 4;
  localparam int ADDR_W = 64;
  localparam int CFG_AW = 8;
  localparam int CFG_DW = 32;

  // one full beat in bytes, sized to the offset registers
  localparam logic [CFG_DW-1:0] BEAT_BYTES = 64;

  // ----------------------------
  // register map
  // ----------------------------
  localparam logic [CFG_AW-1:0] REG_CTRL    = 8'h00;
  localparam logic [CFG_AW-1:0] REG_CMD     = 8'h08;
  localparam logic [CFG_AW-1:0] REG_RST     = 8'h0c;
  localparam logic [CFG_AW-1:0] REG_BASE_LO = 8'h20;
  localparam logic [CFG_AW-1:0] REG_BASE_HI = 8'h24;
  localparam logic [CFG_AW-1:0] REG_HEAD    = 8'h28;
  localparam logic [CFG_AW-1:0] REG_SIZE    = 8'h30;

  // fsb intake enable inside REG_CTRL
  localparam int CTRL_EN_BIT = 4;

  // ----------------------------
  // types
  // ----------------------------
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [CFG_AW-1:0] addr;
    logic [CFG_DW-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic              ack;
    logic [CFG_DW-1:0] rdata;
  } cfg_rsp_t;

  typedef logic [FSB_W-1:0] fsb_pkt_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  // base, size and head are byte values from software
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [CFG_DW-1:0] size;
    logic [CFG_DW-1:0] head;
  } ring_cfg_t;

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    FILL  = 3'd1,
    DATA  = 3'd2,
    TAIL  = 3'd3,
    PAUSE = 3'd4
  } wr_state_t;

endpackage

/* rtl/fsb_cfg_regs.sv */
// ----------------------------
// configuration register block
// strobe handshake, storage, readback and command pulses
// ----------------------------
module fsb_cfg_regs
(
  input  logic                   clk,
  input  logic                   sync_rst_n,
  input  fsb_axi_pkg::cfg_req_t  cfg_req_i,
  output fsb_axi_pkg::cfg_rsp_t  cfg_rsp_o,
  input  logic                   status_busy_i,
  input  logic                   stop_pend_i,
  input  logic                   b_valid_i,
  input  logic [1:0]             b_resp_i,
  output fsb_axi_pkg::ring_cfg_t ring_cfg_o,
  output logic                   fsb_en_o,
  output logic                   go_o,
  output logic                   stop_o,
  output logic                   reset_o
);

  logic                                wr_stretch_q;
  logic                                rd_stretch_q;
  logic                                ack_q;
  logic [fsb_axi_pkg::CFG_AW-1:0]      addr_q;
  logic [fsb_axi_pkg::CFG_DW-1:0]      wdata_q;
  logic [fsb_axi_pkg::CFG_DW-1:0]      rdata_q;
  logic                                fsb_en_q;
  logic [fsb_axi_pkg::ADDR_W-1:0]      base_q;
  logic [fsb_axi_pkg::CFG_DW-1:0]      head_q;
  logic [fsb_axi_pkg::CFG_DW-1:0]      size_q;
  logic [1:0]                          bresp_q;
  logic                                wr_commit;
  logic                                rd_commit;
  logic                                wr_ack;

  // ----------------------------
  // handshake
  // ----------------------------
  // stretch holds until ack, ack is one cycle after stretch
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_stretch_q <= 1'b0;
      rd_stretch_q <= 1'b0;
      ack_q        <= 1'b0;
    end
    else
    begin
      wr_stretch_q <= cfg_req_i.wr || (wr_stretch_q && !ack_q);
      rd_stretch_q <= cfg_req_i.rd || (rd_stretch_q && !ack_q);
      ack_q        <= (wr_stretch_q || rd_stretch_q) && !ack_q;
    end
  end

  // request payload capture
  always_ff @(posedge clk)
  begin
    if (cfg_req_i.wr || cfg_req_i.rd)
    begin
      addr_q  <= cfg_req_i.addr;
      wdata_q <= cfg_req_i.wdata;
    end
  end

  // one cycle before ack
  assign wr_commit = wr_stretch_q && !ack_q;
  assign rd_commit = rd_stretch_q && !ack_q;
  assign wr_ack    = wr_stretch_q && ack_q;

  // ----------------------------
  // register storage
  // ----------------------------
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      fsb_en_q <= 1'b0;
      base_q   <= '0;
      head_q   <= '0;
      size_q   <= '0;
    end
    else if (wr_commit)
    begin
      case (addr_q)
        fsb_axi_pkg::REG_CTRL:    fsb_en_q      <= wdata_q[fsb_axi_pkg::CTRL_EN_BIT];
        fsb_axi_pkg::REG_BASE_LO: base_q[31:0]  <= wdata_q;
        fsb_axi_pkg::REG_BASE_HI: base_q[63:32] <= wdata_q;
        fsb_axi_pkg::REG_HEAD:    head_q        <= wdata_q;
        fsb_axi_pkg::REG_SIZE:    size_q        <= wdata_q;
        default: ;
      endcase
    end
  end

  // last write response, updated on every b beat
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      bresp_q <= 2'b00;
    else if (b_valid_i)
      bresp_q <= b_resp_i;
  end

  // readback mux, registered so rdata lines up with ack
  always_ff @(posedge clk)
  begin
    if (rd_commit)
    begin
      case (addr_q)
        fsb_axi_pkg::REG_CTRL:    rdata_q <= {27'b0, fsb_en_q, 4'b0};
        fsb_axi_pkg::REG_CMD:     rdata_q <= {28'b0, bresp_q, stop_pend_i, status_busy_i};
        fsb_axi_pkg::REG_BASE_LO: rdata_q <= base_q[31:0];
        fsb_axi_pkg::REG_BASE_HI: rdata_q <= base_q[63:32];
        fsb_axi_pkg::REG_HEAD:    rdata_q <= head_q;
        fsb_axi_pkg::REG_SIZE:    rdata_q <= size_q;
        default:                  rdata_q <= '1;
      endcase
    end
  end

  // ----------------------------
  // command pulses in the ack cycle
  // ----------------------------
  assign go_o    = wr_ack && (addr_q == fsb_axi_pkg::REG_CMD) && wdata_q[0];
  assign stop_o  = wr_ack && (addr_q == fsb_axi_pkg::REG_CMD) && !wdata_q[0];
  assign reset_o = wr_ack && (addr_q == fsb_axi_pkg::REG_RST) && wdata_q[0];

  assign fsb_en_o   = fsb_en_q;
  assign ring_cfg_o = '{base: base_q, size: size_q, head: head_q};
  assign cfg_rsp_o  = '{ack: ack_q, rdata: rdata_q};

endmodule

/* rtl/fsb_beat_packer.sv */
// ----------------------------
// fsb beat packer
// four 80-bit packets into one 512-bit beat
// ----------------------------
module fsb_beat_packer
(
  input  logic                           clk,
  input  logic                           sync_rst_n,
  input  logic                           fsb_valid_i,
  input  fsb_axi_pkg::fsb_pkt_t          fsb_data_i,
  output logic                           fsb_yumi_o,
  input  logic                           fsb_en_i,
  input  logic                           fill_i,
  input  logic                           take_i,
  output logic                           beat_full_o,
  output logic [fsb_axi_pkg::DATA_W-1:0] beat_o
);

  logic [$clog2(fsb_axi_pkg::LANES)-1:0] lane_q;
  logic                                  full_q;
  logic [fsb_axi_pkg::DATA_W-1:0]        beat_q;

  // dequeue only while filling and the beat has room
  assign fsb_yumi_o = fsb_valid_i && fsb_en_i && fill_i && !full_q;

  // lane counter and full flag
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      lane_q <= '0;
      full_q <= 1'b0;
    end
    else if (take_i)
    begin
      lane_q <= '0;
      full_q <= 1'b0;
    end
    else if (fsb_yumi_o)
    begin
      lane_q <= lane_q + 1'b1;
      // last lane closes the beat
      if (lane_q == fsb_axi_pkg::LANES - 1)
        full_q <= 1'b1;
    end
  end

  // packet k lands zero-extended in lane k
  always_ff @(posedge clk)
  begin
    if (fsb_yumi_o)
      beat_q[lane_q*fsb_axi_pkg::LANE_W +: fsb_axi_pkg::LANE_W] <=
        {{(fsb_axi_pkg::LANE_W-fsb_axi_pkg::FSB_W){1'b0}}, fsb_data_i};
  end

  assign beat_full_o = full_q;
  assign beat_o      = beat_q;

endmodule

/* rtl/ring_ptr.sv */
// ----------------------------
// ring write pointer
// offset with wrap, full check and address forming
// ----------------------------
module ring_ptr
(
  input  logic                           clk,
  input  logic                           sync_rst_n,
  input  fsb_axi_pkg::ring_cfg_t         ring_cfg_i,
  input  logic                           clear_i,
  input  logic                           advance_i,
  output logic [fsb_axi_pkg::ADDR_W-1:0] data_addr_o,
  output logic [fsb_axi_pkg::ADDR_W-1:0] tail_addr_o,
  output logic [fsb_axi_pkg::CFG_DW-1:0] offset_o,
  output logic                           full_o
);

  logic [fsb_axi_pkg::CFG_DW-1:0] offset_q;
  logic [fsb_axi_pkg::CFG_DW-1:0] step;
  logic [fsb_axi_pkg::CFG_DW-1:0] next_off;

  // one beat further, back to zero at buffer size
  assign step     = offset_q + fsb_axi_pkg::BEAT_BYTES;
  assign next_off = (step == ring_cfg_i.size) ? '0 : step;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      offset_q <= '0;
    else if (clear_i)
      offset_q <= '0;
    else if (advance_i)
      offset_q <= next_off;
  end

  // ----------------------------
  // addresses
  // ----------------------------
  // data beat at base + offset, tail word right past the buffer
  assign data_addr_o = ring_cfg_i.base +
                       {{(fsb_axi_pkg::ADDR_W-fsb_axi_pkg::CFG_DW){1'b0}}, offset_q};
  assign tail_addr_o = ring_cfg_i.base +
                       {{(fsb_axi_pkg::ADDR_W-fsb_axi_pkg::CFG_DW){1'b0}}, ring_cfg_i.size};

  // full when one more beat would land on the read head
  // live head compare, so a head write releases the pause
  assign full_o   = (next_off == ring_cfg_i.head);
  assign offset_o = offset_q;

endmodule

/* rtl/axi_chan_slot.sv */
// ----------------------------
// one-entry axi channel register
// ----------------------------
module axi_chan_slot
#(
  parameter type payload_t = logic
)
(
  input  logic     clk,
  input  logic     sync_rst_n,
  input  logic     load_i,
  input  payload_t payload_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t payload_o,
  output logic     busy_o
);

  payload_t payload_q;
  logic     valid_q;

  // valid held until the handshake, load wins over the drop
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      valid_q <= 1'b0;
    else if (load_i)
      valid_q <= 1'b1;
    else if (ready_i)
      valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
      payload_q <= payload_i;
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;
  assign busy_o    = valid_q;

endmodule

/* rtl/axi_wr_ctrl.sv */
// ----------------------------
// axi write control FSM
// fill, data beat, tail post and pause sequencing
// ----------------------------
module axi_wr_ctrl
(
  input  logic                           clk,
  input  logic                           sync_rst_n,
  input  logic                           go_i,
  input  logic                           stop_i,
  input  logic                           reset_i,
  input  logic                           beat_full_i,
  input  logic [fsb_axi_pkg::DATA_W-1:0] beat_i,
  input  logic                           aw_busy_i,
  input  logic                           w_busy_i,
  input  logic [fsb_axi_pkg::CFG_DW-1:0] offset_i,
  input  logic [fsb_axi_pkg::ADDR_W-1:0] data_addr_i,
  input  logic [fsb_axi_pkg::ADDR_W-1:0] tail_addr_i,
  input  logic                           full_i,
  output logic                           fill_o,
  output logic                           take_o,
  output logic                           clear_o,
  output logic                           advance_o,
  output logic                           aw_load_o,
  output fsb_axi_pkg::axi_aw_t           aw_o,
  output logic                           w_load_o,
  output fsb_axi_pkg::axi_w_t            w_o,
  output logic                           busy_o,
  output logic                           stop_pend_o
);

  fsb_axi_pkg::wr_state_t state_q;
  fsb_axi_pkg::wr_state_t state_d;
  logic                   stop_pend_q;
  logic                   stop_now;
  logic                   slots_idle;
  logic                   load_data;
  logic                   load_tail;

  // both channels have handed off their payload
  assign slots_idle = !aw_busy_i && !w_busy_i;
  assign stop_now   = stop_pend_q || stop_i;
  assign load_data  = (state_q == fsb_axi_pkg::FILL) && beat_full_i;
  assign load_tail  = (state_q == fsb_axi_pkg::DATA) && slots_idle;

  // ----------------------------
  // next state
  // ----------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      fsb_axi_pkg::IDLE:
        if (go_i)
          state_d = fsb_axi_pkg::FILL;
      fsb_axi_pkg::FILL:
        if (beat_full_i)
          state_d = fsb_axi_pkg::DATA;
      fsb_axi_pkg::DATA:
        if (slots_idle)
          state_d = fsb_axi_pkg::TAIL;
      fsb_axi_pkg::TAIL:
        if (slots_idle)
          state_d = (stop_now || full_i) ? fsb_axi_pkg::PAUSE : fsb_axi_pkg::FILL;
      fsb_axi_pkg::PAUSE:
      begin
        if (reset_i)
          state_d = fsb_axi_pkg::IDLE;
        else if (!full_i && !stop_now)
          state_d = fsb_axi_pkg::FILL;
      end
      default:
        state_d = fsb_axi_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      state_q     <= fsb_axi_pkg::IDLE;
      stop_pend_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // stop stays pending until the FSM is back in idle
      stop_pend_q <= stop_now && (state_d != fsb_axi_pkg::IDLE);
    end
  end

  // ----------------------------
  // payloads
  // ----------------------------
  // data beat while filling, tail word otherwise
  // pointer moves as the beat is committed, so the tail sees the new offset
  always_comb
  begin
    aw_o.len  = 8'd0;
    w_o.last  = 1'b1;
    if (state_q == fsb_axi_pkg::FILL)
    begin
      aw_o.addr = data_addr_i;
      w_o.data  = beat_i;
      w_o.strb  = '1;
    end
    else
    begin
      aw_o.addr = tail_addr_i;
      w_o.data  = {{(fsb_axi_pkg::DATA_W-fsb_axi_pkg::CFG_DW){1'b1}}, offset_i};
      w_o.strb  = {{(fsb_axi_pkg::STRB_W-8){1'b0}}, 8'hff};
    end
  end

  assign aw_load_o = load_data || load_tail;
  assign w_load_o  = load_data || load_tail;
  assign take_o    = load_data;
  assign advance_o = load_data;
  assign fill_o    = (state_q == fsb_axi_pkg::FILL);

  // reset command rewinds the ring once writes are parked
  assign clear_o = reset_i &&
                   ((state_q == fsb_axi_pkg::IDLE) || (state_q == fsb_axi_pkg::PAUSE));

  assign busy_o      = (state_q == fsb_axi_pkg::FILL) || (state_q == fsb_axi_pkg::DATA) ||
                       (state_q == fsb_axi_pkg::TAIL);
  assign stop_pend_o = stop_pend_q;

endmodule

/* rtl/fsb_axi_wr_top.sv */
// ----------------------------
// fsb to axi4 write adapter top
// ----------------------------
module fsb_axi_wr_top
(
  input  logic                  clk,
  input  logic                  sync_rst_n,
  input  fsb_axi_pkg::cfg_req_t cfg_req_i,
  output fsb_axi_pkg::cfg_rsp_t cfg_rsp_o,
  input  logic                  fsb_valid_i,
  input  fsb_axi_pkg::fsb_pkt_t fsb_data_i,
  output logic                  fsb_yumi_o,
  output fsb_axi_pkg::axi_aw_t  aw_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output fsb_axi_pkg::axi_w_t   w_o,
  output logic                  w_valid_o,
  input  logic                  w_ready_i,
  input  logic                  b_valid_i,
  input  logic [1:0]            b_resp_i,
  output logic                  b_ready_o
);

  fsb_axi_pkg::ring_cfg_t         ring_cfg;
  fsb_axi_pkg::axi_aw_t           aw_load_pl;
  fsb_axi_pkg::axi_w_t            w_load_pl;
  logic [fsb_axi_pkg::DATA_W-1:0] beat;
  logic [fsb_axi_pkg::ADDR_W-1:0] data_addr;
  logic [fsb_axi_pkg::ADDR_W-1:0] tail_addr;
  logic [fsb_axi_pkg::CFG_DW-1:0] offset;
  logic fsb_en;
  logic go;
  logic stop;
  logic rst_cmd;
  logic busy;
  logic stop_pend;
  logic beat_full;
  logic fill;
  logic take;
  logic clear;
  logic advance;
  logic full;
  logic aw_load;
  logic w_load;
  logic aw_busy;
  logic w_busy;

  // b channel only feeds the status register
  assign b_ready_o = 1'b1;

  fsb_cfg_regs u_regs (
    .clk(clk), .sync_rst_n(sync_rst_n), .cfg_req_i(cfg_req_i), .cfg_rsp_o(cfg_rsp_o),
    .status_busy_i(busy), .stop_pend_i(stop_pend), .b_valid_i(b_valid_i),
    .b_resp_i(b_resp_i), .ring_cfg_o(ring_cfg), .fsb_en_o(fsb_en), .go_o(go),
    .stop_o(stop), .reset_o(rst_cmd)
  );

  fsb_beat_packer u_packer (
    .clk(clk), .sync_rst_n(sync_rst_n), .fsb_valid_i(fsb_valid_i), .fsb_data_i(fsb_data_i),
    .fsb_yumi_o(fsb_yumi_o), .fsb_en_i(fsb_en), .fill_i(fill), .take_i(take),
    .beat_full_o(beat_full), .beat_o(beat)
  );

  ring_ptr u_ring (
    .clk(clk), .sync_rst_n(sync_rst_n), .ring_cfg_i(ring_cfg), .clear_i(clear),
    .advance_i(advance), .data_addr_o(data_addr), .tail_addr_o(tail_addr),
    .offset_o(offset), .full_o(full)
  );

  axi_wr_ctrl u_ctrl (
    .clk(clk), .sync_rst_n(sync_rst_n), .go_i(go), .stop_i(stop), .reset_i(rst_cmd),
    .beat_full_i(beat_full), .beat_i(beat), .aw_busy_i(aw_busy), .w_busy_i(w_busy),
    .offset_i(offset), .data_addr_i(data_addr), .tail_addr_i(tail_addr), .full_i(full),
    .fill_o(fill), .take_o(take), .clear_o(clear), .advance_o(advance),
    .aw_load_o(aw_load), .aw_o(aw_load_pl), .w_load_o(w_load), .w_o(w_load_pl),
    .busy_o(busy), .stop_pend_o(stop_pend)
  );

  // aw and w complete independently, one slot each
  axi_chan_slot #(.payload_t(fsb_axi_pkg::axi_aw_t)) u_aw_slot (
    .clk(clk), .sync_rst_n(sync_rst_n), .load_i(aw_load), .payload_i(aw_load_pl),
    .valid_o(aw_valid_o), .ready_i(aw_ready_i), .payload_o(aw_o), .busy_o(aw_busy)
  );

  axi_chan_slot #(.payload_t(fsb_axi_pkg::axi_w_t)) u_w_slot (
    .clk(clk), .sync_rst_n(sync_rst_n), .load_i(w_load), .payload_i(w_load_pl),
    .valid_o(w_valid_o), .ready_i(w_ready_i), .payload_o(w_o), .busy_o(w_busy)
  );

endmodule

/* bench/fsb_axi_chk.sv */
// ----------------------------
// handshake checker for the adapter top
// ----------------------------
module fsb_axi_chk
(
  input logic                  clk,
  input logic                  sync_rst_n,
  input fsb_axi_pkg::cfg_req_t cfg_req_i,
  input fsb_axi_pkg::cfg_rsp_t cfg_rsp_i,
  input logic                  fsb_valid_i,
  input logic                  fsb_yumi_i,
  input fsb_axi_pkg::axi_aw_t  aw_i,
  input logic                  aw_valid_i,
  input logic                  aw_ready_i,
  input fsb_axi_pkg::axi_w_t   w_i,
  input logic                  w_valid_i,
  input logic                  w_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // failed assertion count
  int fail_cnt = 0;

  // ----------------------------
  // channel back-pressure
  // ----------------------------
  // aw payload frozen while stalled
  a_aw_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (aw_valid_i && !aw_ready_i) |=> (aw_valid_i && $stable(aw_i)))
  else
  begin
    $error("aw payload changed under back-pressure");
    fail_cnt++;
  end

  // same for w
  a_w_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
    (w_valid_i && !w_ready_i) |=> (w_valid_i && $stable(w_i)))
  else
  begin
    $error("w payload changed under back-pressure");
    fail_cnt++;
  end

  // dequeue only a packet that is offered, and never with a write in flight
  a_yumi_valid: assert property (@(posedge clk) disable iff (!sync_rst_n)
    fsb_yumi_i |-> (fsb_valid_i && !aw_valid_i && !w_valid_i))
  else
  begin
    $error("yumi without valid or during a write");
    fail_cnt++;
  end

  // ack two cycles after a request, single cycle
  a_ack_pulse: assert property (@(posedge clk) disable iff (!sync_rst_n)
    cfg_rsp_i.ack |-> ($past(cfg_req_i.wr || cfg_req_i.rd, 2) && !$past(cfg_rsp_i.ack)))
  else
  begin
    $error("ack not a single pulse two cycles after the request");
    fail_cnt++;
  end

endmodule

/* bench/fsb_axi_tb.sv */
// ----------------------------
// testbench for the fsb to axi4 write adapter
// table-driven rows, ring model, random stalls
// ----------------------------
module fsb_axi_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // one stimulus row: ring setup, beat count, stall mode
  typedef struct packed {
    logic [63:0] base;
    logic [31:0] size;
    logic [31:0] head;
    logic [7:0]  beats;
    logic        stall;
  } row_t;

  logic                  clk;
  logic                  sync_rst_n;
  fsb_axi_pkg::cfg_req_t cfg_req;
  fsb_axi_pkg::cfg_rsp_t cfg_rsp;
  logic                  fsb_valid;
  fsb_axi_pkg::fsb_pkt_t fsb_data;
  logic                  fsb_yumi;
  fsb_axi_pkg::axi_aw_t  aw;
  logic                  aw_valid;
  logic                  aw_ready;
  fsb_axi_pkg::axi_w_t   w;
  logic                  w_valid;
  logic                  w_ready;
  logic                  b_valid;
  logic [1:0]            b_resp;
  logic                  b_ready;

  fsb_axi_pkg::fsb_pkt_t pkt_q[$];
  fsb_axi_pkg::fsb_pkt_t exp_pkts[$];
  fsb_axi_pkg::axi_aw_t  aw_got[$];
  fsb_axi_pkg::axi_w_t   w_got[$];
  logic                  stall_en;
  logic                  b_pend;
  logic [31:0]           data_seed;
  logic [31:0]           stall_seed;
  row_t                  rows [5];

  fsb_axi_wr_top UUT (
    .clk(clk), .sync_rst_n(sync_rst_n), .cfg_req_i(cfg_req), .cfg_rsp_o(cfg_rsp),
    .fsb_valid_i(fsb_valid), .fsb_data_i(fsb_data), .fsb_yumi_o(fsb_yumi),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_resp_i(b_resp), .b_ready_o(b_ready)
  );

  bind fsb_axi_wr_top fsb_axi_chk u_chk (
    .clk(clk), .sync_rst_n(sync_rst_n), .cfg_req_i(cfg_req_i), .cfg_rsp_i(cfg_rsp_o),
    .fsb_valid_i(fsb_valid_i), .fsb_yumi_i(fsb_yumi_o),
    .aw_i(aw_o), .aw_valid_i(aw_valid_o), .aw_ready_i(aw_ready_i),
    .w_i(w_o), .w_valid_i(w_valid_o), .w_ready_i(w_ready_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------
  // helpers
  // ----------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_aw(input fsb_axi_pkg::axi_aw_t got, input fsb_axi_pkg::axi_aw_t exp);
    if (got !== exp)
    begin
      $display("Error: aw_o got %h expected %h", got, exp);
      fail_now("aw payload mismatch");
    end
  endtask

  task automatic check_w(input fsb_axi_pkg::axi_w_t got, input fsb_axi_pkg::axi_w_t exp);
    if (got !== exp)
    begin
      $display("Error: w_o got %h expected %h", got, exp);
      fail_now("w payload mismatch");
    end
  endtask

  task automatic check_rsp(input fsb_axi_pkg::cfg_rsp_t got, input fsb_axi_pkg::cfg_rsp_t exp);
    if (got !== exp)
    begin
      $display("Error: cfg_rsp_o got %h expected %h", got, exp);
      fail_now("config response mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      fail_now("control output mismatch");
    end
  endtask

  // one request, ack must come on the second cycle
  task automatic cfg_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output fsb_axi_pkg::cfg_rsp_t rsp);
    int n;
    @(negedge clk);
    cfg_req = '{wr: wr, rd: !wr, addr: addr, wdata: wdata};
    @(negedge clk);
    cfg_req.wr = 1'b0;
    cfg_req.rd = 1'b0;
    n = 1;
    while (!cfg_rsp.ack && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    if (!cfg_rsp.ack)
      fail_now("timeout waiting for the configuration ack");
    if (n != 2)
      fail_now("configuration ack did not come two cycles after the request");
    rsp = cfg_rsp;
  endtask

  task automatic cfg_write(input logic [7:0] addr, input logic [31:0] wdata);
    fsb_axi_pkg::cfg_rsp_t rsp;
    cfg_access(1'b1, addr, wdata, rsp);
  endtask

  task automatic cfg_read_check(input logic [7:0] addr, input logic [31:0] exp);
    fsb_axi_pkg::cfg_rsp_t rsp;
    cfg_access(1'b0, addr, '0, rsp);
    check_rsp(rsp, '{ack: 1'b1, rdata: exp});
  endtask

  // random packets into the driver queue and the model
  task automatic push_pkts(input int n);
    fsb_axi_pkg::fsb_pkt_t p;
    for (int i = 0; i < n; i++)
    begin
      data_seed = lcg_next(data_seed);
      p[79:64] = data_seed[31:16];
      data_seed = lcg_next(data_seed);
      p[63:32] = data_seed;
      data_seed = lcg_next(data_seed);
      p[31:0] = data_seed;
      pkt_q.push_back(p);
      exp_pkts.push_back(p);
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (pkt_q.size() != 0 && t < 500)
    begin
      @(negedge clk);
      t++;
    end
    if (pkt_q.size() != 0)
      fail_now("timeout waiting for the FSB packets to be taken");
  endtask

  task automatic wait_transfers();
    int t;
    t = 0;
    while ((aw_got.size() < 2 || w_got.size() < 2) && t < 2000)
    begin
      @(negedge clk);
      t++;
    end
    if (aw_got.size() < 2 || w_got.size() < 2)
      fail_now("timeout waiting for the data and tail writes");
  endtask

  // status polled until the FSM has parked
  task automatic wait_parked(input logic [31:0] exp);
    fsb_axi_pkg::cfg_rsp_t rsp;
    int t;
    t = 0;
    cfg_access(1'b0, fsb_axi_pkg::REG_CMD, '0, rsp);
    while (rsp.rdata[0] && t < 100)
    begin
      cfg_access(1'b0, fsb_axi_pkg::REG_CMD, '0, rsp);
      t++;
    end
    if (rsp.rdata[0])
      fail_now("timeout waiting for busy to clear after stop");
    check_rsp(rsp, '{ack: 1'b1, rdata: exp});
  endtask

  // ----------------------------
  // FSB source
  // ----------------------------
  initial
  begin
    forever
    begin
      @(negedge clk);
      fsb_valid = (pkt_q.size() != 0);
      fsb_data  = (pkt_q.size() != 0) ? pkt_q[0] : '0;
      @(posedge clk);
      if (fsb_yumi)
        void'(pkt_q.pop_front());
    end
  end

  // ----------------------------
  // AXI slave side
  // ----------------------------
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (UUT.u_chk.fail_cnt != 0)
        fail_now("a bound handshake assertion failed");
      b_valid = b_pend;
      // slverr on the stalled rows, okay otherwise
      b_resp  = b_pend ? {stall_en, 1'b0} : 2'b00;
      b_pend  = 1'b0;
      if (stall_en)
      begin
        stall_seed = lcg_next(stall_seed);
        aw_ready   = (stall_seed[17:16] != 2'b00);
        stall_seed = lcg_next(stall_seed);
        w_ready    = (stall_seed[17:16] != 2'b00);
      end
      else
      begin
        aw_ready = 1'b1;
        w_ready  = 1'b1;
      end
      @(posedge clk);
      if (sync_rst_n && aw_valid && aw_ready)
        aw_got.push_back(aw);
      if (sync_rst_n && w_valid && w_ready)
      begin
        w_got.push_back(w);
        b_pend = 1'b1;
      end
    end
  end

  // ----------------------------
  // main sequence
  // ----------------------------
  initial
  begin
    logic [31:0]                    off;
    logic [31:0]                    new_off;
    logic [31:0]                    head;
    logic [fsb_axi_pkg::DATA_W-1:0] beat;
    int                             pre;
    row_t                           row;

    sync_rst_n = 1'b0;
    cfg_req    = '0;
    fsb_valid  = 1'b0;
    fsb_data   = '0;
    aw_ready   = 1'b0;
    w_ready    = 1'b0;
    b_valid    = 1'b0;
    b_resp     = 2'b00;
    b_pend     = 1'b0;
    stall_en   = 1'b0;
    data_seed  = 32'd97;
    stall_seed = lcg_next(32'd97);

    // base, size, head, beats, stall
    rows[0] = '{64'h0000_0001_0000_0000, 32'h400, 32'hffff_ffff, 8'd3, 1'b0};
    // wraps after four beats
    rows[1] = '{64'h0000_0000_8000_1000, 32'h100, 32'hffff_ffff, 8'd6, 1'b0};
    // full after the first beat
    rows[2] = '{64'h0000_0000_0000_2000, 32'h100, 32'h80, 8'd4, 1'b0};
    rows[3] = '{64'h0000_0002_0004_0000, 32'h200, 32'hffff_ffff, 8'd10, 1'b1};
    rows[4] = '{64'h0000_0000_0005_0000, 32'hc0, 32'h40, 8'd5, 1'b1};

    repeat (5) @(posedge clk);
    @(negedge clk);
    sync_rst_n = 1'b1;

    // idle outputs after reset
    @(negedge clk);
    check_bit("aw_valid_o", aw_valid, 1'b0);
    check_bit("w_valid_o", w_valid, 1'b0);
    check_bit("fsb_yumi_o", fsb_yumi, 1'b0);
    check_bit("cfg_rsp_o.ack", cfg_rsp.ack, 1'b0);
    check_bit("b_ready_o", b_ready, 1'b1);
    cfg_read_check(fsb_axi_pkg::REG_CMD, 32'h0);
    cfg_read_check(8'h04, 32'hffff_ffff);

    for (int r = 0; r < 5; r++)
    begin
      row = rows[r];
      stall_en = row.stall;
      cfg_write(fsb_axi_pkg::REG_BASE_LO, row.base[31:0]);
      cfg_write(fsb_axi_pkg::REG_BASE_HI, row.base[63:32]);
      cfg_write(fsb_axi_pkg::REG_SIZE, row.size);
      cfg_write(fsb_axi_pkg::REG_HEAD, row.head);
      cfg_write(fsb_axi_pkg::REG_CTRL, 32'h10);
      cfg_read_check(fsb_axi_pkg::REG_BASE_LO, row.base[31:0]);
      cfg_read_check(fsb_axi_pkg::REG_BASE_HI, row.base[63:32]);
      cfg_read_check(fsb_axi_pkg::REG_SIZE, row.size);
      cfg_read_check(fsb_axi_pkg::REG_HEAD, row.head);
      cfg_read_check(fsb_axi_pkg::REG_CTRL, 32'h10);

      off  = '0;
      head = row.head;
      pre  = 0;
      cfg_write(fsb_axi_pkg::REG_CMD, 32'h1);

      for (int b = 0; b < int'(row.beats); b++)
      begin
        // stop goes in while the last beat is still filling
        if (b == int'(row.beats) - 1)
        begin
          push_pkts(3 - pre);
          wait_drain();
          cfg_write(fsb_axi_pkg::REG_CMD, 32'h0);
          push_pkts(1);
        end
        else
          push_pkts(4 - pre);
        pre = 0;

        beat = '0;
        for (int k = 0; k < 4; k++)
          beat[k*128 +: 128] = {48'b0, exp_pkts.pop_front()};
        new_off = (off + 32'd64 == row.size) ? 32'd0 : off + 32'd64;

        wait_transfers();
        // data beat, then tail word with the new offset
        check_aw(aw_got.pop_front(), '{addr: row.base + {32'b0, off}, len: 8'd0});
        check_w(w_got.pop_front(), '{data: beat, strb: '1, last: 1'b1});
        check_aw(aw_got.pop_front(), '{addr: row.base + {32'b0, row.size}, len: 8'd0});
        check_w(w_got.pop_front(),
                '{data: {{480{1'b1}}, new_off}, strb: 64'hff, last: 1'b1});
        off = new_off;

        // ring full, intake must hold until head moves
        if (((off + 32'd64 == row.size) ? 32'd0 : off + 32'd64) == head &&
            b != int'(row.beats) - 1)
        begin
          pre = (b + 1 == int'(row.beats) - 1) ? 3 : 4;
          push_pkts(pre);
          repeat (8) @(negedge clk);
          if (pkt_q.size() != pre)
            fail_now("FSB packets were taken while the ring was full");
          cfg_write(fsb_axi_pkg::REG_HEAD, off);
          head = off;
        end
      end

      // parked with stop pending and the last b response, then reset back to idle
      wait_parked({28'b0, row.stall, 1'b0, 2'b10});
      cfg_write(fsb_axi_pkg::REG_RST, 32'h1);
      cfg_read_check(fsb_axi_pkg::REG_CMD, {28'b0, row.stall, 1'b0, 2'b00});
      if (aw_got.size() != 0 || w_got.size() != 0)
        fail_now("unexpected extra AXI write transfer");
    end

    if (UUT.u_chk.fail_cnt != 0)
      fail_now("a bound handshake assertion failed");
    else
    begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

/* sim.f */
rtl/fsb_axi_pkg.sv
rtl/fsb_cfg_regs.sv
rtl/fsb_beat_packer.sv
rtl/ring_ptr.sv
rtl/axi_chan_slot.sv
rtl/axi_wr_ctrl.sv
rtl/fsb_axi_wr_top.sv
bench/fsb_axi_chk.sv
bench/fsb_axi_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the adapter testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f sim.f \
       --top-module fsb_axi_tb -o fsb_axi_sim \
  && ./obj_dir/fsb_axi_sim \
  || { echo "simulation failed"; exit 1; }
